//--- hw/tile_mem_pkg.sv
/*
 * Tile memory concentrator definitions
 * Bus widths, tile window geometry and the request and response words
 * shared by the arbiter, the request mux and the shared memory
 */

`default_nettype none

package tile_mem_pkg;

   localparam integer NUM_TILES = 4;
   localparam integer TILE_IDX_BITS = 2;

   localparam integer WB_ADDR_BITS = 32;
   localparam integer WB_DATA_BITS = 32;
   localparam integer WB_SEL_BITS = 4;

   // Byte address to word index
   localparam integer BYTE_OFS_BITS = 2;

   // 256 words per tile window
   localparam integer LOCAL_WORD_BITS = 8;
   localparam integer MEM_WORD_BITS = TILE_IDX_BITS + LOCAL_WORD_BITS;

   typedef logic [TILE_IDX_BITS-1:0] tile_idx_t;

   typedef struct packed {
      logic                    cyc;
      logic                    stb;
      logic                    we;
      logic [WB_ADDR_BITS-1:0] adr;
      logic [WB_DATA_BITS-1:0] dat;
      logic [WB_SEL_BITS-1:0]  sel;
   } wb_req_t;

   typedef struct packed {
      logic                    ack;
      logic                    err;
      logic [WB_DATA_BITS-1:0] dat;
   } wb_rsp_t;

   // Tile index sits above the local word index
   typedef union packed {
      logic [MEM_WORD_BITS-1:0] raw;
      struct packed {
         tile_idx_t                  tile;
         logic [LOCAL_WORD_BITS-1:0] word;
      } split;
   } mem_addr_u;

   typedef struct packed {
      logic                    we;
      mem_addr_u               addr;
      logic [WB_DATA_BITS-1:0] dat;
      logic [WB_SEL_BITS-1:0]  sel;
   } mem_req_t;

endpackage

`default_nettype wire

//--- hw/tile_mem_arbiter.sv
/*
 * Tile memory arbiter
 * Round-robin grant over the tile ports and a three-state sequencer
 * that drives the memory access and the response pulse
 */

`timescale 1ns/1ps
`default_nettype none

module tile_mem_arbiter (
   input  wire logic                    clk_i,
   input  wire logic                    arst_n_i,
   input  tile_mem_pkg::wb_req_t        req_i [tile_mem_pkg::NUM_TILES],
   input  wire logic                    out_of_range_i,
   output tile_mem_pkg::tile_idx_t      grant_o,
   output logic                         mem_en_o,
   output logic                         mem_we_o,
   output logic                         rsp_valid_o,
   output logic                         rsp_err_o
);

   typedef enum logic [1:0] {
      IDLE,
      ACCESS,
      RESPOND
   } state_t;

   state_t                              state_q;
   tile_mem_pkg::tile_idx_t             grant_q;
   logic [tile_mem_pkg::NUM_TILES-1:0]  pending;
   tile_mem_pkg::tile_idx_t             cand;
   tile_mem_pkg::tile_idx_t             pick;
   logic                                pick_found;
   logic                                granted_active;

   always_comb begin
      for (int t = 0; t < tile_mem_pkg::NUM_TILES; t++) begin
         pending[t] = req_i[t].cyc && req_i[t].stb;
      end
   end

   // Search starts one past the last granted tile
   always_comb begin
      pick_found = 1'b0;
      pick = grant_q;
      cand = grant_q;
      for (int i = 1; i <= tile_mem_pkg::NUM_TILES; i++) begin
         cand = tile_mem_pkg::tile_idx_t'(grant_q + i);
         if (!pick_found && pending[cand]) begin
            pick_found = 1'b1;
            pick = cand;
         end
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= IDLE;
         grant_q <= tile_mem_pkg::tile_idx_t'(tile_mem_pkg::NUM_TILES - 1);
      end else begin
         case (state_q)
            IDLE: begin
               if (pick_found) begin
                  grant_q <= pick;
                  state_q <= ACCESS;
               end
            end
            ACCESS: begin
               state_q <= RESPOND;
            end
            RESPOND: begin
               state_q <= IDLE;
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   assign granted_active = pending[grant_q];

   // Grant stays put until the next IDLE pick
   assign grant_o = grant_q;

   assign mem_en_o = (state_q == ACCESS) && granted_active;
   assign mem_we_o = mem_en_o && req_i[grant_q].we && !out_of_range_i;

   assign rsp_valid_o = (state_q == RESPOND) && granted_active;
   assign rsp_err_o = rsp_valid_o && out_of_range_i;

endmodule

`default_nettype wire

//--- hw/tile_req_mux.sv
/*
 * Tile request mux
 * Selects the granted tile request, prefixes its word index with the
 * tile number and steers the response back to that tile
 */

`timescale 1ns/1ps
`default_nettype none

module tile_req_mux (
   input  tile_mem_pkg::wb_req_t                    req_i [tile_mem_pkg::NUM_TILES],
   input  tile_mem_pkg::tile_idx_t                  grant_i,
   input  wire logic                                mem_we_i,
   input  wire logic                                rsp_valid_i,
   input  wire logic                                rsp_err_i,
   input  wire logic [tile_mem_pkg::WB_DATA_BITS-1:0] rd_data_i,
   output tile_mem_pkg::mem_req_t                   mem_req_o,
   output logic                                     out_of_range_o,
   output tile_mem_pkg::wb_rsp_t                    rsp_o [tile_mem_pkg::NUM_TILES]
);

   localparam integer WIN_TOP = tile_mem_pkg::LOCAL_WORD_BITS + tile_mem_pkg::BYTE_OFS_BITS;

   tile_mem_pkg::wb_req_t sel_req;
   logic                  rsp_ack;

   assign sel_req = req_i[grant_i];

   // Anything above the 1 KiB window
   assign out_of_range_o = |sel_req.adr[tile_mem_pkg::WB_ADDR_BITS-1:WIN_TOP];

   always_comb begin
      mem_req_o.we = mem_we_i;
      mem_req_o.addr.split.tile = grant_i;
      mem_req_o.addr.split.word = sel_req.adr[WIN_TOP-1:tile_mem_pkg::BYTE_OFS_BITS];
      mem_req_o.dat = sel_req.dat;
      mem_req_o.sel = sel_req.sel;
   end

   assign rsp_ack = rsp_valid_i && !rsp_err_i;

   // Only the granted port ever sees a nonzero response
   always_comb begin
      for (int t = 0; t < tile_mem_pkg::NUM_TILES; t++) begin
         rsp_o[t] = '0;
         if (tile_mem_pkg::tile_idx_t'(t) == grant_i) begin
            rsp_o[t].ack = rsp_ack;
            rsp_o[t].err = rsp_valid_i && rsp_err_i;
            if (rsp_ack && !sel_req.we) begin
               rsp_o[t].dat = rd_data_i;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/shared_mem.sv
/*
 * Shared word memory
 * Single port, byte-masked writes, read word registered on the access edge
 */

`timescale 1ns/1ps
`default_nettype none

module shared_mem (
   input  wire logic                                  clk_i,
   input  wire logic                                  mem_en_i,
   input  tile_mem_pkg::mem_req_t                     mem_req_i,
   output logic [tile_mem_pkg::WB_DATA_BITS-1:0]      rd_data_o
);

   localparam integer DEPTH = 2 ** tile_mem_pkg::MEM_WORD_BITS;

   logic [tile_mem_pkg::WB_DATA_BITS-1:0] mem_q [DEPTH];
   logic [tile_mem_pkg::WB_DATA_BITS-1:0] cur_word;
   logic [tile_mem_pkg::WB_DATA_BITS-1:0] wr_word;
   logic [tile_mem_pkg::WB_DATA_BITS-1:0] rd_data_q;

   assign cur_word = mem_q[mem_req_i.addr.raw];

   // Merge selected bytes over the stored word
   always_comb begin
      wr_word = cur_word;
      for (int b = 0; b < tile_mem_pkg::WB_SEL_BITS; b++) begin
         if (mem_req_i.sel[b]) begin
            wr_word[8*b +: 8] = mem_req_i.dat[8*b +: 8];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (mem_en_i) begin
         if (mem_req_i.we) begin
            mem_q[mem_req_i.addr.raw] <= wr_word;
            rd_data_q <= wr_word;
         end else begin
            rd_data_q <= cur_word;
         end
      end
   end

   assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

//--- hw/tile_mem_top.sv
/*
 * Tile memory concentrator
 * Four Wishbone tile ports share one memory through a round-robin arbiter
 */

`timescale 1ns/1ps
`default_nettype none

module tile_mem_top (
   input  wire logic              clk_i,
   input  wire logic              arst_n_i,
   input  tile_mem_pkg::wb_req_t  wb_req_i [tile_mem_pkg::NUM_TILES],
   output tile_mem_pkg::wb_rsp_t  wb_rsp_o [tile_mem_pkg::NUM_TILES]
);

   tile_mem_pkg::tile_idx_t                grant;
   logic                                   mem_en;
   logic                                   mem_we;
   logic                                   rsp_valid;
   logic                                   rsp_err;
   logic                                   out_of_range;
   tile_mem_pkg::mem_req_t                 mem_req;
   logic [tile_mem_pkg::WB_DATA_BITS-1:0]  rd_data;

   tile_mem_arbiter u_arbiter (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .req_i          (wb_req_i),
      .out_of_range_i (out_of_range),
      .grant_o        (grant),
      .mem_en_o       (mem_en),
      .mem_we_o       (mem_we),
      .rsp_valid_o    (rsp_valid),
      .rsp_err_o      (rsp_err)
   );

   tile_req_mux u_mux (
      .req_i          (wb_req_i),
      .grant_i        (grant),
      .mem_we_i       (mem_we),
      .rsp_valid_i    (rsp_valid),
      .rsp_err_i      (rsp_err),
      .rd_data_i      (rd_data),
      .mem_req_o      (mem_req),
      .out_of_range_o (out_of_range),
      .rsp_o          (wb_rsp_o)
   );

   // Stands in for the DRAM
   shared_mem u_mem (
      .clk_i          (clk_i),
      .mem_en_i       (mem_en),
      .mem_req_i      (mem_req),
      .rd_data_o      (rd_data)
   );

endmodule

`default_nettype wire

//--- test/tile_mem_asserts.sv
/*
 * Tile memory response checks
 * Wishbone response rules on every tile port, bound to the top level
 */

`timescale 1ns/1ps
`default_nettype none

module tile_mem_asserts (
   input  wire logic              clk_i,
   input  wire logic              arst_n_i,
   input  tile_mem_pkg::wb_req_t  wb_req_i [tile_mem_pkg::NUM_TILES],
   input  tile_mem_pkg::wb_rsp_t  wb_rsp_i [tile_mem_pkg::NUM_TILES]
);

   logic [tile_mem_pkg::NUM_TILES-1:0] resp;
   logic [tile_mem_pkg::NUM_TILES-1:0] both;
   logic [tile_mem_pkg::NUM_TILES-1:0] active;

   always_comb begin
      for (int t = 0; t < tile_mem_pkg::NUM_TILES; t++) begin
         resp[t] = wb_rsp_i[t].ack || wb_rsp_i[t].err;
         both[t] = wb_rsp_i[t].ack && wb_rsp_i[t].err;
         active[t] = wb_req_i[t].cyc && wb_req_i[t].stb;
      end
   end

   a_one_port: assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(resp))
      else $error("more than one tile port responded in one cycle");

   for (genvar t = 0; t < tile_mem_pkg::NUM_TILES; t++) begin : g_port
      a_ack_err: assert property (@(posedge clk_i) disable iff (!arst_n_i) !both[t])
         else $error("port %0d has ack and err together", t);
      a_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                   resp[t] |-> active[t])
         else $error("port %0d responded without cyc and stb", t);
      a_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                    resp[t] |=> !resp[t])
         else $error("port %0d response lasted more than one cycle", t);
   end

endmodule

`default_nettype wire

//--- test/tile_mem_tb.sv
/*
 * Tile memory concentrator testbench
 * Directed tests over the four Wishbone tile ports, checked against a word model
 */

`timescale 1ns/1ps
`default_nettype none

module tile_mem_tb;

   localparam integer CLK_PERIOD = 100;
   localparam integer DRV_DLY = 10;
   localparam integer MEM_WORDS = 1024;
   // About 300 cycles of traffic at 3 to 4 cycles per access
   localparam integer MAX_CYCLES = 2000;
   localparam logic [31:0] CONTEND_ADR = 32'h0000_00C0;

   logic                  clk;
   logic                  arst_n;
   tile_mem_pkg::wb_req_t wb_req [tile_mem_pkg::NUM_TILES];
   tile_mem_pkg::wb_rsp_t wb_rsp [tile_mem_pkg::NUM_TILES];

   logic [31:0] ref_mem [MEM_WORDS];
   logic        written [MEM_WORDS];
   logic [31:0] lfsr;
   int          cycle_cnt = 0;
   int          error_cnt = 0;
   int          check_cnt = 0;
   int          test_cnt = 0;
   int          test_err_start = 0;
   string       test_name = "";

   tile_mem_top dut0 (
      .clk_i    (clk),
      .arst_n_i (arst_n),
      .wb_req_i (wb_req),
      .wb_rsp_o (wb_rsp)
   );

   bind tile_mem_top tile_mem_asserts u_asserts (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .wb_req_i (wb_req_i),
      .wb_rsp_i (wb_rsp_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: no end of tests after %0d cycles", cycle_cnt);
         $display("Finished with errors");
         $finish;
      end
   end

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        b;
      r = '0;
      for (int i = 0; i < n; i++) begin
         b = lfsr[0];
         lfsr = {1'b0, lfsr[31:1]};
         if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
         end
         r = {r[30:0], b};
      end
      return r;
   endfunction

   // Tile number in front of the local word index
   function automatic logic [9:0] global_index(input int tile, input logic [31:0] adr);
      return {tile_mem_pkg::tile_idx_t'(tile), adr[tile_mem_pkg::LOCAL_WORD_BITS+1:2]};
   endfunction

   task automatic model_write(input int tile, input logic [31:0] adr,
                              input logic [31:0] dat, input logic [3:0] sel);
      logic [9:0] idx;
      idx = global_index(tile, adr);
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            ref_mem[idx][8*b +: 8] = dat[8*b +: 8];
         end
      end
      written[idx] = 1'b1;
   endtask

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      check_cnt++;
      if (act !== exp) begin
         error_cnt++;
         $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic open_test(input string name);
      test_name = name;
      test_err_start = error_cnt;
      test_cnt++;
   endtask

   task automatic close_test();
      if (error_cnt == test_err_start) begin
         $display("%s: ok", test_name);
      end else begin
         $display("%s: %0d errors", test_name, error_cnt - test_err_start);
      end
   endtask

   // One classic cycle
   // Edges counted from the first sampling edge to the response
   task automatic single_access(input int tile, input logic we, input logic [31:0] adr,
                                input logic [31:0] dat, input logic [3:0] sel,
                                input logic expect_err, output logic [31:0] rdata,
                                output int edges);
      int   waited;
      logic got_ack;
      logic got_err;
      waited = 0;
      got_ack = 1'b0;
      got_err = 1'b0;
      @(posedge clk);
      #DRV_DLY;
      wb_req[tile].cyc = 1'b1;
      wb_req[tile].stb = 1'b1;
      wb_req[tile].we = we;
      wb_req[tile].adr = adr;
      wb_req[tile].dat = dat;
      wb_req[tile].sel = sel;
      while (!got_ack && !got_err) begin
         @(negedge clk);
         waited++;
         got_ack = wb_rsp[tile].ack;
         got_err = wb_rsp[tile].err;
      end
      rdata = wb_rsp[tile].dat;
      edges = waited - 1;
      @(posedge clk);
      #DRV_DLY;
      wb_req[tile] = '0;
      if (expect_err && got_ack) begin
         error_cnt++;
         $display("error in %s: tile %0d got ack where err was expected", test_name, tile);
      end else if (!expect_err && got_err) begin
         error_cnt++;
         $display("error in %s: tile %0d got err where ack was expected", test_name, tile);
      end
   endtask

   task automatic wb_write(input int tile, input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, input logic expect_err);
      logic [31:0] unused_rd;
      int          edges;
      single_access(tile, 1'b1, adr, dat, sel, expect_err, unused_rd, edges);
      if (!expect_err) begin
         model_write(tile, adr, dat, sel);
      end
   endtask

   task automatic wb_read(input int tile, input logic [31:0] adr, input logic expect_err,
                          output logic [31:0] rdata, output int edges);
      single_access(tile, 1'b0, adr, 32'h0, 4'h0, expect_err, rdata, edges);
   endtask

   // All tiles raise stb together and are served one per access
   task automatic contend_round(input logic we);
      logic [3:0]  done;
      logic [3:0]  done_now;
      int          order [tile_mem_pkg::NUM_TILES];
      int          seen;
      int          waited;
      logic [31:0] dat;
      done = '0;
      seen = 0;
      waited = 0;
      for (int i = 0; i < tile_mem_pkg::NUM_TILES; i++) begin
         order[i] = -1;
      end
      @(posedge clk);
      #DRV_DLY;
      for (int t = 0; t < tile_mem_pkg::NUM_TILES; t++) begin
         dat = rand_bits(32);
         wb_req[t].cyc = 1'b1;
         wb_req[t].stb = 1'b1;
         wb_req[t].we = we;
         wb_req[t].adr = CONTEND_ADR;
         wb_req[t].dat = dat;
         wb_req[t].sel = 4'hf;
         if (we) begin
            model_write(t, CONTEND_ADR, dat, 4'hf);
         end
      end
      while (done != 4'hf && waited < 40) begin
         @(negedge clk);
         waited++;
         done_now = '0;
         for (int t = 0; t < tile_mem_pkg::NUM_TILES; t++) begin
            if (wb_rsp[t].ack || wb_rsp[t].err) begin
               done_now[t] = 1'b1;
               if (seen < tile_mem_pkg::NUM_TILES) begin
                  order[seen] = t;
               end
               seen++;
               if (wb_rsp[t].err) begin
                  error_cnt++;
                  $display("error in %s: tile %0d got err on an in-window access", test_name, t);
               end else if (!we) begin
                  check_value($sformatf("tile %0d data", t),
                              ref_mem[global_index(t, CONTEND_ADR)], wb_rsp[t].dat);
               end
            end
         end
         if ($countones(done_now) > 1) begin
            error_cnt++;
            $display("error in %s: %0d tiles answered in one cycle", test_name,
                     $countones(done_now));
         end
         @(posedge clk);
         #DRV_DLY;
         for (int t = 0; t < tile_mem_pkg::NUM_TILES; t++) begin
            if (done_now[t]) begin
               wb_req[t] = '0;
            end
         end
         done = done | done_now;
      end
      if (done != 4'hf) begin
         error_cnt++;
         $display("error in %s: not every tile got a response", test_name);
      end
      for (int i = 0; i < tile_mem_pkg::NUM_TILES; i++) begin
         check_value($sformatf("grant slot %0d", i), i, order[i]);
      end
   endtask

   task automatic contention_order();
      open_test("contention_order");
      contend_round(1'b1);
      contend_round(1'b0);
      close_test();
   endtask

   task automatic tile_isolation();
      logic [31:0] rdata;
      int          edges;
      open_test("tile_isolation");
      for (int t = 0; t < tile_mem_pkg::NUM_TILES; t++) begin
         wb_write(t, 32'h10, 32'hC0DE_0000 | t, 4'hf, 1'b0);
      end
      for (int t = 0; t < tile_mem_pkg::NUM_TILES; t++) begin
         wb_read(t, 32'h10, 1'b0, rdata, edges);
         check_value($sformatf("tile %0d", t), ref_mem[global_index(t, 32'h10)], rdata);
      end
      close_test();
   endtask

   task automatic byte_select();
      logic [31:0] rdata;
      int          edges;
      open_test("byte_select");
      wb_write(1, 32'h40, 32'h1122_3344, 4'hf, 1'b0);
      wb_write(1, 32'h40, 32'hAABB_CCDD, 4'b0101, 1'b0);
      wb_read(1, 32'h40, 1'b0, rdata, edges);
      check_value("merged word", ref_mem[global_index(1, 32'h40)], rdata);
      check_value("merged literal", 32'h11BB_33DD, rdata);
      close_test();
   endtask

   task automatic window_error();
      logic [31:0] rdata;
      int          edges;
      open_test("window_error");
      wb_write(2, 32'h20, 32'h5A5A_0F0F, 4'hf, 1'b0);
      // Bit 10 lies above the 1 KiB window and aliases word 0x20
      wb_write(2, 32'h420, 32'hDEAD_BEEF, 4'hf, 1'b1);
      wb_read(2, 32'h420, 1'b1, rdata, edges);
      wb_read(2, 32'h20, 1'b0, rdata, edges);
      check_value("aliased word", ref_mem[global_index(2, 32'h20)], rdata);
      close_test();
   endtask

   task automatic fixed_latency();
      logic [31:0] rdata;
      int          edges;
      open_test("fixed_latency");
      wb_read(3, 32'h10, 1'b0, rdata, edges);
      check_value("ack edges", 2, edges);
      check_value("data", ref_mem[global_index(3, 32'h10)], rdata);
      close_test();
   endtask

   task automatic random_traffic();
      int          tile;
      logic [7:0]  word;
      logic [31:0] adr;
      logic        we;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic [9:0]  idx;
      logic [31:0] rdata;
      int          edges;
      open_test("random_traffic");
      for (int n = 0; n < 40; n++) begin
         tile = int'(rand_bits(2));
         // Small word pool so that reads find written data
         word = 8'(rand_bits(3));
         we = rand_bits(1) != 0;
         dat = rand_bits(32);
         sel = 4'(rand_bits(4));
         adr = {22'h0, word, 2'b00};
         idx = global_index(tile, adr);
         // Fresh words get a full write first
         if (!written[idx]) begin
            we = 1'b1;
            sel = 4'hf;
         end
         if (we) begin
            wb_write(tile, adr, dat, sel, 1'b0);
         end else begin
            wb_read(tile, adr, 1'b0, rdata, edges);
            check_value($sformatf("tile %0d word %0d", tile, word), ref_mem[idx], rdata);
         end
      end
      close_test();
   endtask

   initial begin
      arst_n = 1'b0;
      lfsr = 32'd85168;
      for (int t = 0; t < tile_mem_pkg::NUM_TILES; t++) begin
         wb_req[t] = '0;
      end
      for (int i = 0; i < MEM_WORDS; i++) begin
         written[i] = 1'b0;
      end
      repeat (5) @(posedge clk);
      #DRV_DLY;
      arst_n = 1'b1;

      // Must run first so that tile 0 has priority
      contention_order();
      tile_isolation();
      byte_select();
      window_error();
      fixed_latency();
      random_traffic();

      $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
      if (error_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
hw/tile_mem_pkg.sv
hw/tile_mem_arbiter.sv
hw/tile_req_mux.sv
hw/shared_mem.sv
hw/tile_mem_top.sv
test/tile_mem_asserts.sv
test/tile_mem_tb.sv

//--- Makefile
# Verilator build for the tile memory concentrator

TOP   := tile_mem_tb
BUILD := obj_dir
LOG   := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) \
		-Mdir $(BUILD) -o $(TOP)_sim
	-./$(BUILD)/$(TOP)_sim > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
